// ==== Makefile ====
# Verilator build and run of the rp_lite testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_lite
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, a missing result line counts as failure
run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+include
rtl/rp_pkg.sv
rtl/axil_reg_port.sv
rtl/sys_regs.sv
rtl/adc_in_loop.sv
rtl/dac_out.sv
rtl/pdm_mod.sv
rtl/rp_lite_top.sv
test/tb_rp_lite.sv

// ==== include/rp_defs.svh ====
// widths, channel counts, register byte offsets and fixed constants
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

//////////////////////////////
// channel counts
//////////////////////////////

// ADC and DAC channels
`define RP_CHN      2
// PDM outputs
`define RP_PDM_CHN  4

//////////////////////////////
// data widths
//////////////////////////////

`define RP_ADC_W    16
`define RP_DAC_W    14
`define RP_PDM_W    8
// PDM full range, one period in cycles
`define RP_PDM_RNG  255

// register bus
`define RP_AXI_AW   8
`define RP_AXI_DW   32

//////////////////////////////
// constants and address map
//////////////////////////////

// identification word
`define RP_ID_VALUE 32'h5250_0001
// DAC mid-scale code
`define RP_DAC_RST  14'h1FFF

// byte offsets, one 32 bit word each
`define RP_A_ID     8'h00
`define RP_A_LOOP   8'h04
`define RP_A_DAC0   8'h08
`define RP_A_DAC1   8'h0C
// four PDM levels from here on
`define RP_A_PDM0   8'h10
`define RP_A_ADC0   8'h20
`define RP_A_ADC1   8'h24

`endif

// ==== rtl/adc_in_loop.sv ====
// ADC input registers, two's complement conversion and DAC loopback select
`timescale 1ns/10ps
`include "rp_defs.svh"

module adc_in_loop import rp_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  adc_smp_t [`RP_CHN-1:0]   adc_dat_i,
  input  logic     [`RP_CHN-1:0]   loop_i,
  input  dac_smp_t [`RP_CHN-1:0]   dac_lvl_i,
  output adc_smp_t [`RP_CHN-1:0]   adc_smp_o
);

  // DAC to ADC width step
  localparam int unsigned LSH = `RP_ADC_W - `RP_DAC_W;

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn
    adc_smp_t raw_q;
    adc_smp_t conv;
    adc_smp_t lpbk;
    adc_smp_t smp_q;

    // IO register, raw pin data
    always_ff @(posedge adc_clk) begin
      raw_q <= adc_dat_i[i];
    end

    // negative slope into two's complement
    assign conv = {raw_q[`RP_ADC_W-1], ~raw_q[`RP_ADC_W-2:0]};
    // DAC level scaled up, zero LSBs
    assign lpbk = {dac_lvl_i[i], {LSH{1'b0}}};

    // loop bit picks the DAC level over the pins
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        smp_q <= '0;
      end else if (loop_i[i]) begin
        smp_q <= lpbk;
      end else begin
        smp_q <= conv;
      end
    end

    assign adc_smp_o[i] = smp_q;
  end

endmodule

// ==== rtl/axil_reg_port.sv ====
// AXI4-Lite slave port with write strobes, read data capture and response hold
`timescale 1ns/10ps
`include "rp_defs.svh"

module axil_reg_port import rp_pkg::*; (
  input  logic                       adc_clk,
  input  logic                       top_rst,
  // write address and data
  input  logic [`RP_AXI_AW-1:0]      s_axil_awaddr_i,
  input  logic                       s_axil_awvalid_i,
  output logic                       s_axil_awready_o,
  input  logic [`RP_AXI_DW-1:0]      s_axil_wdata_i,
  input  logic [`RP_AXI_DW/8-1:0]    s_axil_wstrb_i,
  input  logic                       s_axil_wvalid_i,
  output logic                       s_axil_wready_o,
  // write response
  output logic [1:0]                 s_axil_bresp_o,
  output logic                       s_axil_bvalid_o,
  input  logic                       s_axil_bready_i,
  // read address and data
  input  logic [`RP_AXI_AW-1:0]      s_axil_araddr_i,
  input  logic                       s_axil_arvalid_i,
  output logic                       s_axil_arready_o,
  output logic [`RP_AXI_DW-1:0]      s_axil_rdata_o,
  output logic [1:0]                 s_axil_rresp_o,
  output logic                       s_axil_rvalid_o,
  input  logic                       s_axil_rready_i,
  // register block side
  output logic                       reg_wr_o,
  output logic [`RP_AXI_AW-1:0]      reg_wr_addr_o,
  output logic [`RP_AXI_DW-1:0]      reg_wr_data_o,
  output logic [`RP_AXI_AW-1:0]      reg_rd_addr_o,
  input  logic [`RP_AXI_DW-1:0]      reg_rd_data_i
);

  axil_st_e st_q;
  axil_st_e st_d;
  logic     wr_go;
  logic     rd_go;
  logic [`RP_AXI_DW-1:0] rdata_q;

  //////////////////////////////
  // acceptance
  //////////////////////////////

  // write needs AW and W together, full words only, strobes not looked at
  assign wr_go = (st_q == ST_IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
  // read only when no write is offered
  assign rd_go = (st_q == ST_IDLE) && s_axil_arvalid_i && !wr_go;

  assign s_axil_awready_o = wr_go;
  assign s_axil_wready_o  = wr_go;
  assign s_axil_arready_o = rd_go;

  // strobe to register block in the accept cycle
  assign reg_wr_o      = wr_go;
  assign reg_wr_addr_o = s_axil_awaddr_i;
  assign reg_wr_data_o = s_axil_wdata_i;
  // read data comes back combinationally
  assign reg_rd_addr_o = s_axil_araddr_i;

  //////////////////////////////
  // response FSM
  //////////////////////////////

  always_comb begin
    st_d = st_q;
    case (st_q)
      ST_IDLE: begin
        if (wr_go) begin
          st_d = ST_BRESP;
        end else if (rd_go) begin
          st_d = ST_RRESP;
        end
      end
      // hold until the master takes it
      ST_BRESP: begin
        if (s_axil_bready_i) begin
          st_d = ST_IDLE;
        end
      end
      ST_RRESP: begin
        if (s_axil_rready_i) begin
          st_d = ST_IDLE;
        end
      end
      default: begin
        st_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      st_q <= ST_IDLE;
    end else begin
      st_q <= st_d;
    end
  end

  // read data captured at acceptance
  always_ff @(posedge adc_clk) begin
    if (rd_go) begin
      rdata_q <= reg_rd_data_i;
    end
  end

  assign s_axil_bvalid_o = (st_q == ST_BRESP);
  assign s_axil_rvalid_o = (st_q == ST_RRESP);
  assign s_axil_rdata_o  = rdata_q;
  // always OKAY
  assign s_axil_bresp_o  = 2'b00;
  assign s_axil_rresp_o  = 2'b00;

  // responses wait for the master, read data does not move meanwhile
  a_bvalid_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

  a_rvalid_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
    s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o));

  a_one_resp: assert property (@(posedge adc_clk) disable iff (top_rst)
    !(s_axil_bvalid_o && s_axil_rvalid_o));

endmodule

// ==== rtl/dac_out.sv ====
// DAC output registers with offset conversion, mid-scale reset and loop hold
`timescale 1ns/10ps
`include "rp_defs.svh"

module dac_out import rp_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  dac_smp_t [`RP_CHN-1:0]   dac_lvl_i,
  input  logic     [`RP_CHN-1:0]   loop_i,
  output logic     [`RP_DAC_W-1:0] dac_dat0_o,
  output logic     [`RP_DAC_W-1:0] dac_dat1_o
);

  logic [`RP_CHN-1:0][`RP_DAC_W-1:0] dac_raw;

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn
    logic [`RP_DAC_W-1:0] dac_q;

    // signed to offset binary, negative slope
    // looped channel keeps its last code
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        dac_q <= `RP_DAC_RST;
      end else if (!loop_i[i]) begin
        dac_q <= {dac_lvl_i[i][`RP_DAC_W-1], ~dac_lvl_i[i][`RP_DAC_W-2:0]};
      end
    end

    assign dac_raw[i] = dac_q;

    // no DAC movement while the channel feeds the ADC path
    a_loop_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
      loop_i[i] |=> $stable(dac_q));
  end

  // parallel channel ports
  assign dac_dat0_o = dac_raw[0];
  assign dac_dat1_o = dac_raw[1];

endmodule

// ==== rtl/pdm_mod.sv ====
// four channel first order pulse-density modulator
`timescale 1ns/10ps
`include "rp_defs.svh"

module pdm_mod import rp_pkg::*; (
  input  logic                         adc_clk,
  input  logic                         top_rst,
  input  pdm_lvl_t [`RP_PDM_CHN-1:0]   pdm_lvl_i,
  output logic     [`RP_PDM_CHN-1:0]   pdm_o
);

  localparam int unsigned     PW  = `RP_PDM_W;
  // one extra bit for the carry
  localparam logic [PW:0]     RNG = `RP_PDM_RNG;

  for (genvar i = 0; i < `RP_PDM_CHN; i++) begin : g_chn
    logic [PW-1:0] acc_q;
    logic [PW:0]   sum;
    logic          hit;
    logic          pdm_q;

    // level added every cycle
    assign sum = {1'b0, acc_q} + {1'b0, pdm_lvl_i[i]};
    assign hit = (sum >= RNG);

    // overflow gives a pulse and leaves the remainder
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        acc_q <= '0;
        pdm_q <= 1'b0;
      end else begin
        pdm_q <= hit;
        acc_q <= hit ? PW'(sum - RNG) : PW'(sum);
      end
    end

    assign pdm_o[i] = pdm_q;

    // remainder never reaches full range
    a_acc_range: assert property (@(posedge adc_clk) disable iff (top_rst)
      {1'b0, acc_q} < RNG);
  end

endmodule

// ==== rtl/rp_lite_top.sv ====
// top level with register port, register block, ADC, DAC and PDM paths
`timescale 1ns/10ps
`include "rp_defs.svh"

module rp_lite_top import rp_pkg::*; (
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // ADC raw samples, offset binary with negative slope
  input  adc_smp_t [`RP_CHN-1:0]       adc_dat_i,
  // DAC channels as parallel ports
  output logic     [`RP_DAC_W-1:0]     dac_dat0_o,
  output logic     [`RP_DAC_W-1:0]     dac_dat1_o,
  // 1 bit PDM outputs
  output logic     [`RP_PDM_CHN-1:0]   pdm_o,
  // AXI4-Lite write channels
  input  logic     [`RP_AXI_AW-1:0]    s_axil_awaddr_i,
  input  logic                         s_axil_awvalid_i,
  output logic                         s_axil_awready_o,
  input  logic     [`RP_AXI_DW-1:0]    s_axil_wdata_i,
  input  logic     [`RP_AXI_DW/8-1:0]  s_axil_wstrb_i,
  input  logic                         s_axil_wvalid_i,
  output logic                         s_axil_wready_o,
  output logic     [1:0]               s_axil_bresp_o,
  output logic                         s_axil_bvalid_o,
  input  logic                         s_axil_bready_i,
  // AXI4-Lite read channels
  input  logic     [`RP_AXI_AW-1:0]    s_axil_araddr_i,
  input  logic                         s_axil_arvalid_i,
  output logic                         s_axil_arready_o,
  output logic     [`RP_AXI_DW-1:0]    s_axil_rdata_o,
  output logic     [1:0]               s_axil_rresp_o,
  output logic                         s_axil_rvalid_o,
  input  logic                         s_axil_rready_i
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // register strobe side
  logic                      reg_wr;
  logic [`RP_AXI_AW-1:0]     reg_wr_addr;
  logic [`RP_AXI_DW-1:0]     reg_wr_data;
  logic [`RP_AXI_AW-1:0]     reg_rd_addr;
  logic [`RP_AXI_DW-1:0]     reg_rd_data;

  // control and sample paths
  logic     [`RP_CHN-1:0]     loop;
  dac_smp_t [`RP_CHN-1:0]     dac_lvl;
  pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl;
  adc_smp_t [`RP_CHN-1:0]     adc_smp;

  //////////////////////////////
  // register bus
  //////////////////////////////

  axil_reg_port u_axil_reg_port (
    .adc_clk          (adc_clk),
    .top_rst          (top_rst),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .reg_wr_o         (reg_wr),
    .reg_wr_addr_o    (reg_wr_addr),
    .reg_wr_data_o    (reg_wr_data),
    .reg_rd_addr_o    (reg_rd_addr),
    .reg_rd_data_i    (reg_rd_data)
  );

  sys_regs u_sys_regs (
    .adc_clk       (adc_clk),
    .top_rst       (top_rst),
    .reg_wr_i      (reg_wr),
    .reg_wr_addr_i (reg_wr_addr),
    .reg_wr_data_i (reg_wr_data),
    .reg_rd_addr_i (reg_rd_addr),
    .reg_rd_data_o (reg_rd_data),
    .adc_smp_i     (adc_smp),
    .loop_o        (loop),
    .dac_lvl_o     (dac_lvl),
    .pdm_lvl_o     (pdm_lvl)
  );

  //////////////////////////////
  // signal paths
  //////////////////////////////

  // ADC input with DAC loopback
  adc_in_loop u_adc_in_loop (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .loop_i    (loop),
    .dac_lvl_i (dac_lvl),
    .adc_smp_o (adc_smp)
  );

  dac_out u_dac_out (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .dac_lvl_i  (dac_lvl),
    .loop_i     (loop),
    .dac_dat0_o (dac_dat0_o),
    .dac_dat1_o (dac_dat1_o)
  );

  pdm_mod u_pdm_mod (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_lvl_i (pdm_lvl),
    .pdm_o     (pdm_o)
  );

endmodule

// ==== rtl/rp_pkg.sv ====
// sample and level types, register word index enum and bus port state enum
`include "rp_defs.svh"

package rp_pkg;

  // signed sample after ADC conversion
  typedef logic signed [`RP_ADC_W-1:0] adc_smp_t;
  // signed DAC level as written by software
  typedef logic signed [`RP_DAC_W-1:0] dac_smp_t;
  // unsigned PDM density
  typedef logic [`RP_PDM_W-1:0] pdm_lvl_t;

  // word index width, byte address minus two LSBs
  localparam int unsigned REG_IW = `RP_AXI_AW - 2;

  // word indexes of the register map
  typedef enum logic [REG_IW-1:0] {
    REG_ID   = REG_IW'(`RP_A_ID >> 2),
    REG_LOOP = REG_IW'(`RP_A_LOOP >> 2),
    REG_DAC0 = REG_IW'(`RP_A_DAC0 >> 2),
    REG_DAC1 = REG_IW'(`RP_A_DAC1 >> 2),
    REG_PDM0 = REG_IW'(`RP_A_PDM0 >> 2),
    REG_PDM1 = REG_IW'((`RP_A_PDM0 >> 2) + 1),
    REG_PDM2 = REG_IW'((`RP_A_PDM0 >> 2) + 2),
    REG_PDM3 = REG_IW'((`RP_A_PDM0 >> 2) + 3),
    REG_ADC0 = REG_IW'(`RP_A_ADC0 >> 2),
    REG_ADC1 = REG_IW'(`RP_A_ADC1 >> 2)
  } reg_idx_e;

  // bus port states, one response outstanding at most
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BRESP,
    ST_RRESP
  } axil_st_e;

endpackage

// ==== rtl/sys_regs.sv ====
// register decode, loop, DAC and PDM storage, read multiplexer with ID and ADC
`timescale 1ns/10ps
`include "rp_defs.svh"

module sys_regs import rp_pkg::*; (
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // strobe side of the bus port
  input  logic                         reg_wr_i,
  input  logic     [`RP_AXI_AW-1:0]    reg_wr_addr_i,
  input  logic     [`RP_AXI_DW-1:0]    reg_wr_data_i,
  input  logic     [`RP_AXI_AW-1:0]    reg_rd_addr_i,
  output logic     [`RP_AXI_DW-1:0]    reg_rd_data_o,
  // ADC samples for readback
  input  adc_smp_t [`RP_CHN-1:0]       adc_smp_i,
  // control outputs
  output logic     [`RP_CHN-1:0]       loop_o,
  output dac_smp_t [`RP_CHN-1:0]       dac_lvl_o,
  output pdm_lvl_t [`RP_PDM_CHN-1:0]   pdm_lvl_o
);

  // zero padding up to a bus word
  localparam int unsigned LOOP_PAD = `RP_AXI_DW - `RP_CHN;
  localparam int unsigned DAC_PAD  = `RP_AXI_DW - `RP_DAC_W;
  localparam int unsigned PDM_PAD  = `RP_AXI_DW - `RP_PDM_W;
  localparam int unsigned ADC_EXT  = `RP_AXI_DW - `RP_ADC_W;

  reg_idx_e wr_idx;
  reg_idx_e rd_idx;

  logic     [`RP_CHN-1:0]     loop_q;
  dac_smp_t [`RP_CHN-1:0]     dac_q;
  pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_q;

  // byte address to word index
  assign wr_idx = reg_idx_e'(reg_wr_addr_i[`RP_AXI_AW-1:2]);
  assign rd_idx = reg_idx_e'(reg_rd_addr_i[`RP_AXI_AW-1:2]);

  //////////////////////////////
  // write side
  //////////////////////////////

  // narrow fields keep the low bits only
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_q <= '0;
      dac_q  <= '0;
      pdm_q  <= '0;
    end else if (reg_wr_i) begin
      case (wr_idx)
        REG_LOOP: loop_q   <= reg_wr_data_i[`RP_CHN-1:0];
        REG_DAC0: dac_q[0] <= reg_wr_data_i[`RP_DAC_W-1:0];
        REG_DAC1: dac_q[1] <= reg_wr_data_i[`RP_DAC_W-1:0];
        REG_PDM0: pdm_q[0] <= reg_wr_data_i[`RP_PDM_W-1:0];
        REG_PDM1: pdm_q[1] <= reg_wr_data_i[`RP_PDM_W-1:0];
        REG_PDM2: pdm_q[2] <= reg_wr_data_i[`RP_PDM_W-1:0];
        REG_PDM3: pdm_q[3] <= reg_wr_data_i[`RP_PDM_W-1:0];
        // ID, ADC and unmapped words ignore writes
        default: begin
        end
      endcase
    end
  end

  assign loop_o    = loop_q;
  assign dac_lvl_o = dac_q;
  assign pdm_lvl_o = pdm_q;

  //////////////////////////////
  // read side
  //////////////////////////////

  always_comb begin
    reg_rd_data_o = '0;
    case (rd_idx)
      REG_ID:   reg_rd_data_o = `RP_ID_VALUE;
      REG_LOOP: reg_rd_data_o = {{LOOP_PAD{1'b0}}, loop_q};
      REG_DAC0: reg_rd_data_o = {{DAC_PAD{1'b0}}, dac_q[0]};
      REG_DAC1: reg_rd_data_o = {{DAC_PAD{1'b0}}, dac_q[1]};
      REG_PDM0: reg_rd_data_o = {{PDM_PAD{1'b0}}, pdm_q[0]};
      REG_PDM1: reg_rd_data_o = {{PDM_PAD{1'b0}}, pdm_q[1]};
      REG_PDM2: reg_rd_data_o = {{PDM_PAD{1'b0}}, pdm_q[2]};
      REG_PDM3: reg_rd_data_o = {{PDM_PAD{1'b0}}, pdm_q[3]};
      // samples are signed, so sign extended
      REG_ADC0: reg_rd_data_o = {{ADC_EXT{adc_smp_i[0][`RP_ADC_W-1]}}, adc_smp_i[0]};
      REG_ADC1: reg_rd_data_o = {{ADC_EXT{adc_smp_i[1][`RP_ADC_W-1]}}, adc_smp_i[1]};
      // unmapped reads return zero
      default:  reg_rd_data_o = '0;
    endcase
  end

  // address from the bus port must be known whenever it strobes
  a_wr_addr_known: assert property (@(posedge adc_clk) disable iff (top_rst)
    reg_wr_i |-> !$isunknown(reg_wr_addr_i));

endmodule

// ==== test/tb_rp_lite.sv ====
// testbench for rp_lite_top with clock, reset, AXI4-Lite tasks, stimulus, checks and report
`timescale 1ns/10ps
`include "rp_defs.svh"

module tb_rp_lite import rp_pkg::*; ();

  // input drive offset after the rising edge
  localparam int DRV_DLY = 2;
  // PDM part about 4 x 300 cycles, all other parts below 600, margin on top
  localparam int MAX_CYCLES = 4000;

  logic                          adc_clk;
  logic                          top_rst;
  adc_smp_t [`RP_CHN-1:0]        adc_dat;
  logic [`RP_DAC_W-1:0]          dac_dat0;
  logic [`RP_DAC_W-1:0]          dac_dat1;
  logic [`RP_PDM_CHN-1:0]        pdm;
  // AXI4-Lite master side
  logic [`RP_AXI_AW-1:0]         s_axil_awaddr;
  logic                          s_axil_awvalid;
  logic                          s_axil_awready;
  logic [`RP_AXI_DW-1:0]         s_axil_wdata;
  logic [`RP_AXI_DW/8-1:0]       s_axil_wstrb;
  logic                          s_axil_wvalid;
  logic                          s_axil_wready;
  logic [1:0]                    s_axil_bresp;
  logic                          s_axil_bvalid;
  logic                          s_axil_bready;
  logic [`RP_AXI_AW-1:0]         s_axil_araddr;
  logic                          s_axil_arvalid;
  logic                          s_axil_arready;
  logic [`RP_AXI_DW-1:0]         s_axil_rdata;
  logic [1:0]                    s_axil_rresp;
  logic                          s_axil_rvalid;
  logic                          s_axil_rready;

  int value_errs;
  int proto_errs;
  int cycles;
  int seed;

  // reference model of loop and DAC registers
  logic [`RP_CHN-1:0]                 loop_m;
  dac_smp_t [`RP_CHN-1:0]             dac_m;
  // expected DAC code, after acceptance and one cycle later
  logic [`RP_CHN-1:0][`RP_DAC_W-1:0]  code_m;
  logic [`RP_CHN-1:0][`RP_DAC_W-1:0]  code_q;

  // writable words for the back-pressure part
  reg_idx_e rw_regs [7] = '{REG_LOOP, REG_DAC0, REG_DAC1, REG_PDM0, REG_PDM1, REG_PDM2, REG_PDM3};

  rp_lite_top i_dut (
    .adc_clk          (adc_clk),
    .top_rst          (top_rst),
    .adc_dat_i        (adc_dat),
    .dac_dat0_o       (dac_dat0),
    .dac_dat1_o       (dac_dat1),
    .pdm_o            (pdm),
    .s_axil_awaddr_i  (s_axil_awaddr),
    .s_axil_awvalid_i (s_axil_awvalid),
    .s_axil_awready_o (s_axil_awready),
    .s_axil_wdata_i   (s_axil_wdata),
    .s_axil_wstrb_i   (s_axil_wstrb),
    .s_axil_wvalid_i  (s_axil_wvalid),
    .s_axil_wready_o  (s_axil_wready),
    .s_axil_bresp_o   (s_axil_bresp),
    .s_axil_bvalid_o  (s_axil_bvalid),
    .s_axil_bready_i  (s_axil_bready),
    .s_axil_araddr_i  (s_axil_araddr),
    .s_axil_arvalid_i (s_axil_arvalid),
    .s_axil_arready_o (s_axil_arready),
    .s_axil_rdata_o   (s_axil_rdata),
    .s_axil_rresp_o   (s_axil_rresp),
    .s_axil_rvalid_o  (s_axil_rvalid),
    .s_axil_rready_i  (s_axil_rready)
  );

  //////////////////////////////
  // clock and timeout
  //////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // output follows the level one cycle after acceptance
  always @(posedge adc_clk) begin
    code_q <= code_m;
  end

  //////////////////////////////
  // reference functions
  //////////////////////////////

  // signed level to offset binary, negative slope
  function automatic logic [`RP_DAC_W-1:0] offset_code(input dac_smp_t lvl);
    return {lvl[`RP_DAC_W-1], ~lvl[`RP_DAC_W-2:0]};
  endfunction

  // raw ADC pins to sign-extended bus word
  function automatic logic [31:0] adc_word(input adc_smp_t raw);
    logic [15:0] smp;
    smp = {raw[15], ~raw[14:0]};
    return {{16{smp[15]}}, smp};
  endfunction

  // looped DAC level, times four
  function automatic logic [31:0] loop_word(input dac_smp_t lvl);
    return {{(`RP_AXI_DW-`RP_ADC_W){lvl[`RP_DAC_W-1]}}, lvl, 2'b00};
  endfunction

  function automatic logic [7:0] byte_addr(input reg_idx_e idx);
    return {idx, 2'b00};
  endfunction

  // bits kept by each writable word
  function automatic logic [31:0] field_mask(input reg_idx_e idx);
    case (idx)
      REG_LOOP: return (32'd1 << `RP_CHN) - 32'd1;
      REG_DAC0, REG_DAC1: return (32'd1 << `RP_DAC_W) - 32'd1;
      default: return (32'd1 << `RP_PDM_W) - 32'd1;
    endcase
  endfunction

  // 0 to 3 cycles of ready delay
  function automatic int ready_delay();
    logic [31:0] r;
    r = $random(seed);
    return int'(r[1:0]);
  endfunction

  function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
    logic [`RP_CHN-1:0] was;
    was = loop_m;
    case (reg_idx_e'(addr[7:2]))
      REG_LOOP: begin
        loop_m = data[`RP_CHN-1:0];
        // released channel jumps to its current level
        for (int c = 0; c < `RP_CHN; c++) begin
          if (was[c] && !loop_m[c]) begin
            code_m[c] = offset_code(dac_m[c]);
          end
        end
      end
      REG_DAC0: begin
        dac_m[0] = data[`RP_DAC_W-1:0];
        if (!loop_m[0]) begin
          code_m[0] = offset_code(dac_m[0]);
        end
      end
      REG_DAC1: begin
        dac_m[1] = data[`RP_DAC_W-1:0];
        if (!loop_m[1]) begin
          code_m[1] = offset_code(dac_m[1]);
        end
      end
      default: begin
      end
    endcase
  endfunction

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    int dly;
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    @(negedge adc_clk);
    while (!(s_axil_awready && s_axil_wready)) @(negedge adc_clk);
    @(posedge adc_clk);
    #DRV_DLY;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    model_write(addr, data);
    dly = ready_delay();
    repeat (dly) begin
      @(posedge adc_clk);
      #DRV_DLY;
    end
    s_axil_bready = 1'b1;
    @(negedge adc_clk);
    while (!s_axil_bvalid) @(negedge adc_clk);
    @(posedge adc_clk);
    #DRV_DLY;
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    int dly;
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    @(negedge adc_clk);
    while (!s_axil_arready) @(negedge adc_clk);
    @(posedge adc_clk);
    #DRV_DLY;
    s_axil_arvalid = 1'b0;
    dly = ready_delay();
    repeat (dly) begin
      @(posedge adc_clk);
      #DRV_DLY;
    end
    s_axil_rready = 1'b1;
    @(negedge adc_clk);
    while (!s_axil_rvalid) @(negedge adc_clk);
    data = s_axil_rdata;
    @(posedge adc_clk);
    #DRV_DLY;
    s_axil_rready = 1'b0;
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // concurrent checks
  //////////////////////////////

  a_dac0_code: assert property (@(posedge adc_clk) disable iff (top_rst)
    dac_dat0 == code_q[0])
    else begin
      value_errs++;
      $display("error %0t dac_dat0_o got %h expected %h", $time, $sampled(dac_dat0),
               $sampled(code_q[0]));
    end

  a_dac1_code: assert property (@(posedge adc_clk) disable iff (top_rst)
    dac_dat1 == code_q[1])
    else begin
      value_errs++;
      $display("error %0t dac_dat1_o got %h expected %h", $time, $sampled(dac_dat1),
               $sampled(code_q[1]));
    end

  a_b_held: assert property (@(posedge adc_clk) disable iff (top_rst)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
      proto_errs++;
      $display("write response withdrawn before it was taken at %0t", $time);
    end

  a_r_held: assert property (@(posedge adc_clk) disable iff (top_rst)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
    else begin
      proto_errs++;
      $display("read response withdrawn or changed before it was taken at %0t", $time);
    end

  a_resp_okay: assert property (@(posedge adc_clk) disable iff (top_rst)
    (!s_axil_bvalid || s_axil_bresp == 2'b00) && (!s_axil_rvalid || s_axil_rresp == 2'b00))
    else begin
      proto_errs++;
      $display("response other than OKAY at %0t", $time);
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [`RP_DAC_W-1:0] held;
    dac_smp_t lvl;
    reg_idx_e idx;
    pdm_lvl_t plvl [`RP_PDM_CHN];
    pdm_lvl_t levels [4];
    int ones [`RP_PDM_CHN];
    seed           = 32'h3c66_02f1;
    value_errs     = 0;
    proto_errs     = 0;
    cycles         = 0;
    loop_m         = '0;
    dac_m          = '0;
    code_m         = {`RP_CHN{`RP_DAC_RST}};
    top_rst        = 1'b1;
    adc_dat        = '0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '1;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    levels         = '{8'd0, 8'd1, 8'd128, 8'd255};
    repeat (2) @(posedge adc_clk);
    #DRV_DLY;
    top_rst = 1'b0;

    // reset state, bus handshake idle
    check_word("s_axil_awready_o", 32'(s_axil_awready), 32'd0);
    check_word("s_axil_wready_o", 32'(s_axil_wready), 32'd0);
    check_word("s_axil_arready_o", 32'(s_axil_arready), 32'd0);
    check_word("s_axil_bvalid_o", 32'(s_axil_bvalid), 32'd0);
    check_word("s_axil_rvalid_o", 32'(s_axil_rvalid), 32'd0);
    axil_read(byte_addr(REG_ID), rd);
    check_word("s_axil_rdata_o (ID)", rd, `RP_ID_VALUE);
    check_word("dac_dat0_o", 32'(dac_dat0), 32'(`RP_DAC_RST));
    check_word("dac_dat1_o", 32'(dac_dat1), 32'(`RP_DAC_RST));
    check_word("pdm_o", 32'(pdm), 32'd0);

    // DAC path
    for (int k = 0; k < 3; k++) begin
      rnd = $random(seed);
      lvl = rnd[`RP_DAC_W-1:0];
      axil_write(byte_addr(REG_DAC0), rnd);
      check_word("dac_dat0_o", 32'(dac_dat0), 32'(offset_code(lvl)));
      rnd = $random(seed);
      lvl = rnd[`RP_DAC_W-1:0];
      axil_write(byte_addr(REG_DAC1), rnd);
      check_word("dac_dat1_o", 32'(dac_dat1), 32'(offset_code(lvl)));
    end

    // ADC path and unmapped words
    for (int k = 0; k < 4; k++) begin
      rnd = $random(seed);
      adc_dat[0] = rnd[15:0];
      adc_dat[1] = rnd[31:16];
      repeat (4) @(posedge adc_clk);
      #DRV_DLY;
      axil_read(byte_addr(REG_ADC0), rd);
      check_word("s_axil_rdata_o (ADC0)", rd, adc_word(adc_dat[0]));
      axil_read(byte_addr(REG_ADC1), rd);
      check_word("s_axil_rdata_o (ADC1)", rd, adc_word(adc_dat[1]));
    end
    axil_read(8'h28, rd);
    check_word("s_axil_rdata_o (0x28)", rd, 32'd0);
    axil_read(8'hFC, rd);
    check_word("s_axil_rdata_o (0xFC)", rd, 32'd0);

    // loopback on channel 0 only
    axil_write(byte_addr(REG_LOOP), 32'd1);
    // code of the last level written before the loop
    held = offset_code(dac_m[0]);
    rnd = $random(seed);
    lvl = rnd[`RP_DAC_W-1:0];
    axil_write(byte_addr(REG_DAC0), rnd);
    repeat (2) @(posedge adc_clk);
    #DRV_DLY;
    check_word("dac_dat0_o", 32'(dac_dat0), 32'(held));
    axil_read(byte_addr(REG_ADC0), rd);
    check_word("s_axil_rdata_o (ADC0 looped)", rd, loop_word(lvl));
    rnd = $random(seed);
    adc_dat[1] = rnd[15:0];
    repeat (4) @(posedge adc_clk);
    #DRV_DLY;
    axil_read(byte_addr(REG_ADC1), rd);
    check_word("s_axil_rdata_o (ADC1)", rd, adc_word(adc_dat[1]));
    axil_write(byte_addr(REG_LOOP), 32'd0);
    check_word("dac_dat0_o", 32'(dac_dat0), 32'(offset_code(lvl)));

    // PDM density, levels rotated over the channels
    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < `RP_PDM_CHN; c++) begin
        plvl[c] = levels[(k + c) % 4];
        axil_write(byte_addr(REG_PDM0) + 8'(4 * c), 32'(plvl[c]));
        ones[c] = 0;
      end
      repeat (4) @(posedge adc_clk);
      repeat (`RP_PDM_RNG) begin
        @(negedge adc_clk);
        for (int c = 0; c < `RP_PDM_CHN; c++) begin
          if (pdm[c]) begin
            ones[c]++;
          end
        end
      end
      for (int c = 0; c < `RP_PDM_CHN; c++) begin
        assert (ones[c] >= int'(plvl[c]) - 1 && ones[c] <= int'(plvl[c]) + 1) else begin
          value_errs++;
          $display("error %0t pdm_o[%0d] got %0d ones expected %0d", $time, c, ones[c], plvl[c]);
        end
      end
      @(posedge adc_clk);
      #DRV_DLY;
    end

    // back-pressure, write then read back with random ready delays
    for (int k = 0; k < 14; k++) begin
      rnd = $random(seed);
      idx = rw_regs[int'(rnd[7:0]) % 7];
      rnd = $random(seed);
      axil_write(byte_addr(idx), rnd);
      axil_read(byte_addr(idx), rd);
      check_word("s_axil_rdata_o (readback)", rd, rnd & field_mask(idx));
    end

    repeat (2) @(posedge adc_clk);
    $display("checks done, %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
